/* dr_to_serial_bridge.f */
hw/dr_bridge_pkg.sv
hw/dr_completion.sv
hw/dr_word_link.sv
hw/p2s_shifter.sv
hw/dr_to_serial_bridge.sv
verification/tb_clock_gen.sv
verification/dr_to_serial_bridge_properties.sv
verification/dr_to_serial_bridge_tb.sv

/* hw/dr_bridge_pkg.sv */
// shared types and constants for the dual-rail to serial bridge
// rail codes are used by the completion stage and the testbench encoder
// the top level takes DEFAULT_WIDTH as its parameter default
package dr_bridge_pkg;

	////////////////////
	// dual-rail coding
	////////////////////

	// one bit on two rails, rail1 in the upper position
	typedef logic [1:0] rail_code_t;

	// spacer between data phases
	localparam rail_code_t RAIL_NULL    = 2'b00;
	// rail0 alone asserted
	localparam rail_code_t RAIL_ZERO    = 2'b01;
	// rail1 alone asserted
	localparam rail_code_t RAIL_ONE     = 2'b10;
	// both rails high, never legal from a well behaved producer
	localparam rail_code_t RAIL_ILLEGAL = 2'b11;

	// word width when the top level is not overridden
	localparam int DEFAULT_WIDTH = 16;

	////////////////////
	// state machines
	////////////////////

	// four-phase handshake position seen by the completion stage
	typedef enum logic {
		PH_WAIT_DATA,
		PH_WAIT_NULL
	} dr_phase_e;

	// serializer activity
	typedef enum logic {
		SH_IDLE,
		SH_SHIFT
	} shift_state_e;

	// serial output pair, split into ports at the top level
	typedef struct packed {
		logic valid;
		logic data;
	} serial_out_t;

endpackage

/* hw/dr_completion.sv */
// input stage of the bridge
// samples the dual-rail bus every clock, detects complete DATA and NULL words
// and runs the return-to-NULL handshake toward the producer on ko
// a complete word is decoded to single rail and strobed into the link
`timescale 1ns/1ps

module dr_completion #(
	parameter int width = dr_bridge_pkg::DEFAULT_WIDTH
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [2*width-1:0] data_in,
	input  logic               link_full,
	output logic               ko,
	output logic               word_strobe,
	output logic [width-1:0]   word,
	output logic               protocol_error
);
	import dr_bridge_pkg::*;

	// registered copy of the rails, pair n holds bit n
	logic [2*width-1:0] din_q;
	// per-bit decode of the registered rails
	logic [width-1:0] bit_valid;
	logic [width-1:0] bit_null;
	logic [width-1:0] bit_illegal;
	logic [width-1:0] rail1_bits;
	dr_phase_e phase;

	////////////////////
	// input register
	////////////////////

	// cleared to all NULL so the first decode sees a spacer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			din_q <= '0;
		end else begin
			din_q <= data_in;
		end
	end

	// classify every pair
	always_comb begin
		rail_code_t pair;
		for (int n = 0; n < width; n++) begin
			pair = din_q[2*n +: 2];
			// exactly one-hot counts as complete
			bit_valid[n]   = (pair == RAIL_ZERO) || (pair == RAIL_ONE);
			bit_null[n]    = (pair == RAIL_NULL);
			bit_illegal[n] = (pair == RAIL_ILLEGAL);
			// rail1 carries the single-rail value
			rail1_bits[n]  = pair[1];
		end
	end

	////////////////////
	// handshake FSM
	////////////////////

	// ko is high for the whole return-to-NULL phase
	assign ko = (phase == PH_WAIT_NULL);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase          <= PH_WAIT_DATA;
			word_strobe    <= 1'b0;
			protocol_error <= 1'b0;
		end else begin
			// strobe lasts one cycle only
			word_strobe <= 1'b0;
			// sticky until reset
			if (|bit_illegal)
				protocol_error <= 1'b1;
			case (phase)
				PH_WAIT_DATA: begin
					// partial or illegal words fail the and-reduction
					// a full link holds the word with ko low
					if (&bit_valid && !link_full) begin
						phase       <= PH_WAIT_NULL;
						word_strobe <= 1'b1;
					end
				end
				PH_WAIT_NULL: begin
					// every pair back at the spacer
					if (&bit_null)
						phase <= PH_WAIT_DATA;
				end
				default: phase <= PH_WAIT_DATA;
			endcase
		end
	end

	// payload, written on the capture edge only
	always_ff @(posedge clk) begin
		if (phase == PH_WAIT_DATA && &bit_valid && !link_full)
			word <= rail1_bits;
	end

endmodule

/* hw/dr_to_serial_bridge.sv */
// top level of the dual-rail to serial bridge
// chains completion, one-word link and serializer
// data_in carries bit n's rails at pair n, rail1 above rail0
// width is set here and passed to every stage
`timescale 1ns/1ps

module dr_to_serial_bridge #(
	parameter int width = dr_bridge_pkg::DEFAULT_WIDTH
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [2*width-1:0] data_in,
	output logic               ko,
	output logic               data_out,
	output logic               data_valid,
	output logic               protocol_error
);
	import dr_bridge_pkg::*;

	// capture to link
	logic             word_strobe;
	logic [width-1:0] word;
	// link to serializer
	logic [width-1:0] link_word;
	logic             link_full;
	logic             take;
	serial_out_t      serial_out;

	dr_completion #(.width(width)) u_completion (
		.clk            (clk),
		.rst_n          (rst_n),
		.data_in        (data_in),
		.link_full      (link_full),
		.ko             (ko),
		.word_strobe    (word_strobe),
		.word           (word),
		.protocol_error (protocol_error)
	);

	dr_word_link #(.width(width)) u_link (
		.clk         (clk),
		.rst_n       (rst_n),
		.word_strobe (word_strobe),
		.word        (word),
		.take        (take),
		.link_word   (link_word),
		.link_full   (link_full)
	);

	p2s_shifter #(.width(width)) u_p2s (
		.clk        (clk),
		.rst_n      (rst_n),
		.link_word  (link_word),
		.link_full  (link_full),
		.take       (take),
		.serial_out (serial_out)
	);

	// split the serial pair into ports
	assign data_out   = serial_out.data;
	assign data_valid = serial_out.valid;

endmodule

/* hw/dr_word_link.sv */
// one-word token buffer between capture and serializer
// a strobe fills it, the serializer empties it with take
// link_full is the only back-pressure path in the bridge
// and is what stalls the completion stage
`timescale 1ns/1ps

module dr_word_link #(
	parameter int width = dr_bridge_pkg::DEFAULT_WIDTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             word_strobe,
	input  logic [width-1:0] word,
	input  logic             take,
	output logic [width-1:0] link_word,
	output logic             link_full
);

	////////////////////
	// token flag
	////////////////////

	// the strobe has priority, so a word arriving while the old one
	// leaves keeps the link occupied
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			link_full <= 1'b0;
		end else if (word_strobe) begin
			link_full <= 1'b1;
		end else if (take) begin
			link_full <= 1'b0;
		end
	end

	////////////////////
	// data holding
	////////////////////

	// written only on a strobe
	// completion never strobes into a full link, so the stored word
	// stays stable until the serializer has loaded it
	always_ff @(posedge clk) begin
		if (word_strobe)
			link_word <= word;
	end

endmodule

/* hw/p2s_shifter.sv */
// parallel to serial output stage
// loads a word from the link and sends it LSB first, one bit per clock
// serial_out.valid stays high for width cycles per word and runs on
// without a gap when the next word is already waiting in the link
`timescale 1ns/1ps

module p2s_shifter #(
	parameter int width = dr_bridge_pkg::DEFAULT_WIDTH
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [width-1:0]          link_word,
	input  logic                      link_full,
	output logic                      take,
	output dr_bridge_pkg::serial_out_t serial_out
);
	import dr_bridge_pkg::*;

	// counter must hold width-1 and be at least one bit wide
	localparam int cnt_w = (width > 1) ? $clog2(width) : 1;

	shift_state_e state;
	// bits still to send, next one in position 0
	logic [width-1:0] shreg;
	// index of the bit now on serial_out
	logic [cnt_w-1:0] cnt;
	logic last_bit;

	assign last_bit = (cnt == cnt_w'(width - 1));

	// load when idle, or on the last bit for back-to-back words
	assign take = link_full && ((state == SH_IDLE) || last_bit);

	////////////////////
	// control
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= SH_IDLE;
			cnt        <= '0;
			serial_out <= '0;
		end else if (take) begin
			// bit 0 goes out straight from the link
			state            <= SH_SHIFT;
			cnt              <= '0;
			serial_out.valid <= 1'b1;
			serial_out.data  <= link_word[0];
		end else if (state == SH_SHIFT) begin
			if (last_bit) begin
				// nothing waiting, drop valid
				state            <= SH_IDLE;
				serial_out.valid <= 1'b0;
			end else begin
				cnt             <= cnt + 1'b1;
				serial_out.data <= shreg[0];
			end
		end
	end

	////////////////////
	// shift register
	////////////////////

	// payload only, follows the control decisions above
	always_ff @(posedge clk) begin
		if (take)
			shreg <= link_word >> 1;
		else if (state == SH_SHIFT)
			shreg <= shreg >> 1;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the bridge testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dr_to_serial_bridge_tb \
	-f dr_to_serial_bridge.f -o sim_bridge || exit 1
./obj_dir/sim_bridge > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

/* verification/dr_to_serial_bridge_properties.sv */
// concurrent checks on the bridge ports
// attached to every bridge instance by the bind at the bottom
`timescale 1ns/1ps

module dr_to_serial_bridge_properties #(
	parameter int width = dr_bridge_pkg::DEFAULT_WIDTH
) (
	input logic               clk,
	input logic               rst_n,
	input logic [2*width-1:0] data_in,
	input logic               ko,
	input logic               data_valid,
	input logic               protocol_error
);
	import dr_bridge_pkg::*;

	// cycles in the current data_valid run
	int run_len;
	// some pair of the input still at the spacer
	logic in_has_null;

	always_ff @(posedge clk) begin
		if (!rst_n)
			run_len <= 0;
		else if (data_valid)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	always_comb begin
		in_has_null = 1'b0;
		for (int n = 0; n < width; n++)
			if (data_in[2*n +: 2] == RAIL_NULL)
				in_has_null = 1'b1;
	end

	////////////////////
	// properties
	////////////////////

	reset_clears_outputs: assert property (@(posedge clk) !rst_n |=> !ko && !data_valid)
		else $error("ko or data_valid high in the cycle after reset");

	// only reset may clear the flag
	error_is_sticky: assert property (@(posedge clk)
		rst_n && $past(rst_n) |-> !$fell(protocol_error))
		else $error("protocol_error fell without a reset");

	valid_whole_words: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(data_valid) |-> (run_len % width) == 0)
		else $error("data_valid run of %0d cycles is not a whole number of words", run_len);

	// the edge that raised ko saw a complete word on data_in
	no_ack_on_null: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ko) |-> !$past(in_has_null))
		else $error("ko rose while data_in still held a NULL pair");

endmodule

bind dr_to_serial_bridge dr_to_serial_bridge_properties #(.width(width)) u_properties (
	.clk            (clk),
	.rst_n          (rst_n),
	.data_in        (data_in),
	.ko             (ko),
	.data_valid     (data_valid),
	.protocol_error (protocol_error)
);

/* verification/dr_to_serial_bridge_tb.sv */
// testbench for the dual-rail to serial bridge
// a producer model runs the four-phase handshake on data_in, a monitor rebuilds
// serial words LSB first and compares them with the acknowledged words in order
// run with run_sim.sh from the project root
`timescale 1ns/1ps

module dr_to_serial_bridge_tb;
	import dr_bridge_pkg::*;

	localparam int width = DEFAULT_WIDTH;
	localparam int n_random = 200;
	localparam int n_burst = 24;
	// every word sent, the illegal one included
	localparam int n_words = 1 + n_random + n_burst + 1 + 1 + 4;
	localparam int limit_ns = n_words * (width + 40) * 20 * 4;

	logic clk;
	logic rst_n;
	logic reset_req;
	logic [2*width-1:0] data_in;
	logic ko;
	logic data_out;
	logic data_valid;
	logic protocol_error;

	logic [31:0] rng_state;
	logic [width-1:0] expected_q[$];
	logic [width-1:0] exp_word;
	string test_name;
	int value_errors;
	int other_errors;
	// monitor state
	logic [width-1:0] rx_word;
	int rx_bits;
	int ack_count;
	int words_done;
	logic ko_seen;
	logic need_valid;

	tb_clock_gen #(.half_period(10), .reset_cycles(5)) u_clock (
		.reset_req (reset_req),
		.clk       (clk),
		.rst_n     (rst_n)
	);

	dr_to_serial_bridge #(.width(width)) dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.data_in        (data_in),
		.ko             (ko),
		.data_out       (data_out),
		.data_valid     (data_valid),
		.protocol_error (protocol_error)
	);

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [width-1:0] random_word();
		logic [31:0] r;
		r = next_random();
		return r[width-1:0];
	endfunction

	// idle cycles between handshake phases, 0 to 15
	function automatic int random_gap();
		return int'(next_random() % 32'd16);
	endfunction

	// rail1 set for a one, rail0 for a zero
	function automatic logic [2*width-1:0] encode_rails(input logic [width-1:0] w);
		logic [2*width-1:0] r;
		for (int n = 0; n < width; n++)
			r[2*n +: 2] = w[n] ? RAIL_ONE : RAIL_ZERO;
		return r;
	endfunction

	task automatic report_mismatch(input string what, input int exp, input int act);
		value_errors++;
		$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
	endtask

	task automatic wait_ko(input logic level);
		while (ko !== level)
			@(negedge clk);
	endtask

	// one four-phase cycle, starts and ends on a falling edge
	task automatic send_word(input logic [width-1:0] w, input bit gaps);
		data_in = encode_rails(w);
		wait_ko(1'b1);
		expected_q.push_back(w);
		repeat (gaps ? random_gap() : 0) @(negedge clk);
		data_in = '0;
		wait_ko(1'b0);
		repeat (gaps ? random_gap() : 0) @(negedge clk);
	endtask

	task automatic drain();
		while (expected_q.size() != 0 || data_valid)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	////////////////////
	// serial monitor
	////////////////////

	always @(negedge clk) begin
		if (!rst_n) begin
			rx_bits = 0;
			ack_count = 0;
			words_done = 0;
			ko_seen = 1'b0;
			need_valid = 1'b0;
		end else begin
			if (need_valid && !data_valid) begin
				other_errors++;
				$display("%s: data_valid dropped although the next word was acknowledged",
					test_name);
			end
			need_valid = 1'b0;
			if (data_valid) begin
				// LSB arrives first, so shift in from the top
				rx_word = {data_out, rx_word[width-1:1]};
				rx_bits++;
				if (rx_bits == width) begin
					if (expected_q.size() == 0) begin
						other_errors++;
						$display("%s: a serial word came out that was never acknowledged",
							test_name);
					end else begin
						exp_word = expected_q.pop_front();
						if (rx_word !== exp_word)
							report_mismatch("serial word", int'(exp_word), int'(rx_word));
					end
					// a later word acked by the previous edge sits in the link
					need_valid = (ack_count > words_done + 1);
					words_done++;
					rx_bits = 0;
				end
			end else if (rx_bits != 0) begin
				other_errors++;
				$display("%s: data_valid run ended after %0d bits", test_name, rx_bits);
				rx_bits = 0;
			end
			if (ko && !ko_seen)
				ack_count++;
			ko_seen = ko;
		end
	end

	////////////////////
	// tests
	////////////////////

	initial begin
		logic [width-1:0] w;
		data_in = '0;
		reset_req = 1'b0;
		rng_state = 32'd93;
		value_errors = 0;
		other_errors = 0;
		test_name = "reset";
		@(posedge rst_n);
		@(negedge clk);
		if (ko !== 1'b0)
			report_mismatch("ko", 0, int'(ko));
		if (data_valid !== 1'b0)
			report_mismatch("data_valid", 0, int'(data_valid));
		if (protocol_error !== 1'b0)
			report_mismatch("protocol_error", 0, int'(protocol_error));

		// ko two cycles after data, low again two cycles after NULL
		test_name = "single_word";
		w = random_word();
		data_in = encode_rails(w);
		@(negedge clk);
		if (ko !== 1'b0)
			report_mismatch("ko one cycle after data", 0, int'(ko));
		@(negedge clk);
		if (ko !== 1'b1)
			report_mismatch("ko two cycles after data", 1, int'(ko));
		expected_q.push_back(w);
		data_in = '0;
		repeat (2) @(negedge clk);
		if (ko !== 1'b0)
			report_mismatch("ko two cycles after NULL", 0, int'(ko));
		drain();

		test_name = "random_stream";
		for (int i = 0; i < n_random; i++)
			send_word(random_word(), 1'b1);
		drain();

		// no gaps, so the link fills and ko stalls
		test_name = "back_pressure";
		for (int i = 0; i < n_burst; i++)
			send_word(random_word(), 1'b0);
		drain();

		// upper half of the pairs still at the spacer
		test_name = "partial_word";
		w = random_word();
		data_in = encode_rails(w) & {{width{1'b0}}, {width{1'b1}}};
		repeat (10) begin
			@(negedge clk);
			if (ko !== 1'b0)
				report_mismatch("ko on partial word", 0, int'(ko));
			if (data_valid !== 1'b0)
				report_mismatch("data_valid on partial word", 0, int'(data_valid));
		end
		send_word(w, 1'b0);
		drain();

		test_name = "illegal_code";
		data_in = encode_rails(random_word());
		data_in[7:6] = RAIL_ILLEGAL;
		repeat (10) begin
			@(negedge clk);
			if (ko !== 1'b0)
				report_mismatch("ko on illegal word", 0, int'(ko));
		end
		if (protocol_error !== 1'b1)
			report_mismatch("protocol_error", 1, int'(protocol_error));
		data_in = '0;
		repeat (3) @(negedge clk);
		if (protocol_error !== 1'b1)
			report_mismatch("protocol_error after NULL", 1, int'(protocol_error));
		reset_req = 1'b1;
		@(negedge rst_n);
		reset_req = 1'b0;
		@(posedge rst_n);
		@(negedge clk);
		if (protocol_error !== 1'b0)
			report_mismatch("protocol_error after reset", 0, int'(protocol_error));
		for (int i = 0; i < 4; i++)
			send_word(random_word(), 1'b1);
		drain();

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(limit_ns);
		$display("watchdog expired, the handshake or the serial output stopped");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
// clock and reset source for the bridge testbench
// reset is held for reset_cycles clocks at start and again after a reset_req pulse
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 10,
	parameter int reset_cycles = 5
) (
	input  logic reset_req,
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		forever begin
			repeat (reset_cycles) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			@(posedge reset_req);
			@(negedge clk);
			rst_n = 1'b0;
		end
	end

endmodule
